// File: hdl/standby_pkg.sv
/*
 * Shared types and constants for the standby and reboot controller.
 * Word values are the 16-bit configuration words as the sequencer emits them,
 * before the per-byte bit reversal that the ICAP port needs.
 */
`default_nettype none

package standby_pkg;

	// ----------------------------------------------------------
	// sequencer states
	// ----------------------------------------------------------
	// word states sit in one contiguous run starting at st_dummy
	typedef enum logic [3:0] {
		st_idle      = 4'd0,
		st_dummy     = 4'd1,
		st_sync1     = 4'd2,
		st_sync2     = 4'd3,
		st_gen1_cmd  = 4'd4,
		st_gen1_data = 4'd5,
		st_gen2_cmd  = 4'd6,
		st_gen2_data = 4'd7,
		st_cmd       = 4'd8,
		st_iprog     = 4'd9,
		st_nop       = 4'd10,
		st_done      = 4'd11
	} seq_state_t;

	// one configuration word with its strobe
	typedef struct packed {
		logic [15:0] data;
		logic        valid;
	} icap_word_t;

	// ----------------------------------------------------------
	// fixed configuration words
	// ----------------------------------------------------------
	localparam logic [15:0] dummy_word = 16'hffff;
	localparam logic [15:0] sync1_word = 16'haa99;
	localparam logic [15:0] sync2_word = 16'h5566;
	// type-1 write headers, one word each
	localparam logic [15:0] gen1_hdr   = 16'h3261;
	localparam logic [15:0] gen2_hdr   = 16'h3281;
	localparam logic [15:0] cmd_hdr    = 16'h30a1;
	localparam logic [15:0] iprog_op   = 16'h000e;
	localparam logic [15:0] nop_word   = 16'h2000;

	// words from dummy through nop
	localparam int seq_len = 10;

endpackage

`default_nettype wire

// File: hdl/button_sync.sv
/*
 * Button conditioning: two-flop synchronizer, then a debounce counter.
 * A new level is accepted after debounce_cycles stable cycles (needs >= 2).
 * press is a one-cycle strobe on each accepted low-to-high change.
 */
`default_nettype none

module button_sync #(
	parameter int debounce_cycles = 50000
) (
	input  logic clk,
	input  logic rst_n,
	input  logic btn,
	output logic press
);

	localparam int cnt_w = $clog2(debounce_cycles + 1);

	logic             btn_meta;
	logic             btn_sync;
	logic             level;
	logic [cnt_w-1:0] stable_cnt;
	logic             accept;

	// ----------------------------------------------------------
	// synchronizer
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_meta <= 1'b0;
			btn_sync <= 1'b0;
		end else begin
			btn_meta <= btn;
			btn_sync <= btn_meta;
		end
	end

	// ----------------------------------------------------------
	// debounce
	// ----------------------------------------------------------
	// last cycle of a long enough run at the new level
	assign accept = (btn_sync != level) &&
			(stable_cnt == cnt_w'(debounce_cycles - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level      <= 1'b0;
			stable_cnt <= '0;
			press      <= 1'b0;
		end else begin
			press <= 1'b0;
			if (btn_sync == level) begin
				// any return to the old level restarts the count
				stable_cnt <= '0;
			end else if (accept) begin
				level      <= btn_sync;
				stable_cnt <= '0;
				press      <= btn_sync;
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/reboot_sequencer.sv
/*
 * Emits the ten-word multiboot and IPROG sequence, one word per cycle.
 * A press in idle starts it; afterwards the FSM parks in done until reset.
 * There is no back-pressure, so the receiver must take every word.
 */
`default_nettype none

module reboot_sequencer #(
	parameter logic [23:0] multiboot_addr = 24'h6e0000,
	parameter logic [7:0]  flash_read_op  = 8'h00
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   press,
	output standby_pkg::icap_word_t word,
	output logic                   busy,
	output logic                   done
);

	standby_pkg::seq_state_t state;
	standby_pkg::seq_state_t next_state;

	logic [15:0] word_data;
	logic        word_valid;

	// true for the states that put a word on the bus
	function automatic logic is_word_state(standby_pkg::seq_state_t s);
		return (int'(s) >= int'(standby_pkg::st_dummy)) &&
			(int'(s) < int'(standby_pkg::st_dummy) + standby_pkg::seq_len);
	endfunction

	// data word belonging to each state
	function automatic logic [15:0] data_for(standby_pkg::seq_state_t s);
		logic [15:0] d;
		case (s)
			standby_pkg::st_dummy:     d = standby_pkg::dummy_word;
			standby_pkg::st_sync1:     d = standby_pkg::sync1_word;
			standby_pkg::st_sync2:     d = standby_pkg::sync2_word;
			standby_pkg::st_gen1_cmd:  d = standby_pkg::gen1_hdr;
			// low half of the boot address
			standby_pkg::st_gen1_data: d = multiboot_addr[15:0];
			standby_pkg::st_gen2_cmd:  d = standby_pkg::gen2_hdr;
			// read opcode over the top address byte
			standby_pkg::st_gen2_data: d = {flash_read_op, multiboot_addr[23:16]};
			standby_pkg::st_cmd:       d = standby_pkg::cmd_hdr;
			standby_pkg::st_iprog:     d = standby_pkg::iprog_op;
			standby_pkg::st_nop:       d = standby_pkg::nop_word;
			default:                   d = 16'h0000;
		endcase
		return d;
	endfunction

	// ----------------------------------------------------------
	// next state
	// ----------------------------------------------------------
	always_comb begin
		next_state = state;
		case (state)
			standby_pkg::st_idle: begin
				if (press)
					next_state = standby_pkg::st_dummy;
			end
			standby_pkg::st_dummy:     next_state = standby_pkg::st_sync1;
			standby_pkg::st_sync1:     next_state = standby_pkg::st_sync2;
			standby_pkg::st_sync2:     next_state = standby_pkg::st_gen1_cmd;
			standby_pkg::st_gen1_cmd:  next_state = standby_pkg::st_gen1_data;
			standby_pkg::st_gen1_data: next_state = standby_pkg::st_gen2_cmd;
			standby_pkg::st_gen2_cmd:  next_state = standby_pkg::st_gen2_data;
			standby_pkg::st_gen2_data: next_state = standby_pkg::st_cmd;
			standby_pkg::st_cmd:       next_state = standby_pkg::st_iprog;
			standby_pkg::st_iprog:     next_state = standby_pkg::st_nop;
			standby_pkg::st_nop:       next_state = standby_pkg::st_done;
			// chip reboots here in hardware
			standby_pkg::st_done:      next_state = standby_pkg::st_done;
			default:                   next_state = standby_pkg::st_idle;
		endcase
	end

	// ----------------------------------------------------------
	// state and word registers
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= standby_pkg::st_idle;
			word_valid <= 1'b0;
		end else begin
			state      <= next_state;
			word_valid <= is_word_state(next_state);
		end
	end

	always_ff @(posedge clk) begin
		word_data <= data_for(next_state);
	end

	assign word = '{data: word_data, valid: word_valid};

	// the state names the word on the bus, so busy lines up with valid
	assign busy = is_word_state(state);
	assign done = (state == standby_pkg::st_done);

endmodule

`default_nettype wire

// File: hdl/icap_writer.sv
/*
 * ICAP output stage with one cycle of latency.
 * Bits are reversed inside each byte, as the ICAP data port expects.
 * BUSY during a write is not retried; it only sets a sticky error flag.
 */
`default_nettype none

module icap_writer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  standby_pkg::icap_word_t word,
	input  logic                   icap_busy,
	output logic [15:0]            icap_data,
	output logic                   icap_ce_n,
	output logic                   icap_write_n,
	output logic                   error
);

	// mirror each byte in place, byte order kept
	function automatic logic [15:0] swap_byte_bits(logic [15:0] d);
		logic [15:0] r;
		for (int i = 0; i < 8; i++) begin
			r[i]     = d[7 - i];
			r[8 + i] = d[15 - i];
		end
		return r;
	endfunction

	// ----------------------------------------------------------
	// output registers
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		icap_data <= swap_byte_bits(word.data);
	end

	// both enables follow valid, write only
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			icap_ce_n    <= 1'b1;
			icap_write_n <= 1'b1;
		end else begin
			icap_ce_n    <= ~word.valid;
			icap_write_n <= ~word.valid;
		end
	end

	// ----------------------------------------------------------
	// busy collision
	// ----------------------------------------------------------
	// word on the port this cycle is lost
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			error <= 1'b0;
		else if (!icap_ce_n && icap_busy)
			error <= 1'b1;
	end

endmodule

`default_nettype wire

// File: hdl/standby_top.sv
/*
 * Standby and reboot controller top level.
 * First ICAP write comes two cycles after the internal press strobe.
 * No clock manager here; clk is expected to be the ICAP-rated clock.
 */
`default_nettype none

module standby_top #(
	parameter int          debounce_cycles = 50000,
	parameter logic [23:0] multiboot_addr  = 24'h6e0000,
	parameter logic [7:0]  flash_read_op   = 8'h00
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        btn_reboot,
	input  logic        icap_busy,
	output logic [15:0] icap_data,
	output logic        icap_ce_n,
	output logic        icap_write_n,
	output logic        led_busy,
	output logic        led_done,
	output logic        led_error
);

	logic                    press;
	standby_pkg::icap_word_t word;

	// ----------------------------------------------------------
	// input side
	// ----------------------------------------------------------
	button_sync #(
		.debounce_cycles(debounce_cycles)
	) u_button_sync (
		.clk  (clk),
		.rst_n(rst_n),
		.btn  (btn_reboot),
		.press(press)
	);

	// ----------------------------------------------------------
	// sequence and ICAP port
	// ----------------------------------------------------------
	reboot_sequencer #(
		.multiboot_addr(multiboot_addr),
		.flash_read_op (flash_read_op)
	) u_reboot_sequencer (
		.clk  (clk),
		.rst_n(rst_n),
		.press(press),
		.word (word),
		.busy (led_busy),
		.done (led_done)
	);

	icap_writer u_icap_writer (
		.clk         (clk),
		.rst_n       (rst_n),
		.word        (word),
		.icap_busy   (icap_busy),
		.icap_data   (icap_data),
		.icap_ce_n   (icap_ce_n),
		.icap_write_n(icap_write_n),
		.error       (led_error)
	);

endmodule

`default_nettype wire

// File: bench/icap_model.sv
/*
 * Behavioral ICAP port. Undoes the per-byte bit reversal and logs each
 * written word with the cycle it was seen in. BUSY is raised during write
 * number busy_slot (counted from 0); -1 never raises it.
 */
`default_nettype none

module icap_model (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [15:0] icap_data,
	input  logic        icap_ce_n,
	input  logic        icap_write_n,
	input  int          busy_slot,
	output logic        icap_busy
);

	logic [15:0] words[$];
	int          stamps[$];
	int          count;
	int          cycle;

	// bit b of a byte comes from bit 7-b of the same byte
	function automatic logic [15:0] unmirror(logic [15:0] d);
		logic [15:0] r;
		for (int b = 0; b < 16; b++)
			r[b] = d[(b / 8) * 8 + 7 - (b % 8)];
		return r;
	endfunction

	assign icap_busy = !icap_ce_n && (count == busy_slot);

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			words.delete();
			stamps.delete();
			count <= 0;
			cycle <= 0;
		end else begin
			cycle <= cycle + 1;
			if (!icap_ce_n && !icap_write_n) begin
				words.push_back(unmirror(icap_data));
				stamps.push_back(cycle);
				count <= count + 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_standby.sv
/*
 * Testbench for standby_top with a short debounce and a test boot address.
 * Outputs are checked at the falling edge; inputs move 5 units after rising.
 */
`default_nettype none

module tb_standby;

	localparam int          period     = 100;
	localparam int          debounce   = 8;
	localparam logic [23:0] boot_addr  = 24'h123456;
	localparam logic [7:0]  read_op    = 8'h0b;
	localparam int          hold       = 20;
	// resets, glitch train, three long presses with their sequences, margin
	localparam int          max_cycles = 3 * 10 + 20 * (1 + 7 + 12) +
		3 * (2 * hold + debounce + 40) + 500;

	logic        clk, rst_n, btn_reboot, icap_busy, icap_ce_n, icap_write_n;
	logic        led_busy, led_done, led_error, activity;
	logic [15:0] icap_data;
	logic [31:0] rnd;
	int          busy_slot, errors, checks, tests;

	standby_top #(.debounce_cycles(debounce), .multiboot_addr(boot_addr),
		.flash_read_op(read_op)) dut (.*);
	icap_model model (.*);

	initial clk = 1'b0;
	always #(period / 2) clk = ~clk;

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	// configuration words in write order
	function automatic logic [15:0] expected_word(int i);
		logic [15:0] w;
		case (i)
			0: w = 16'hffff;
			1: w = 16'haa99;
			2: w = 16'h5566;
			3: w = 16'h3261;
			4: w = boot_addr[15:0];
			5: w = 16'h3281;
			6: w = {read_op, boot_addr[23:16]};
			7: w = 16'h30a1;
			8: w = 16'h000e;
			default: w = 16'h2000;
		endcase
		return w;
	endfunction

	task automatic check(input logic cond, input string msg);
		checks++;
		assert (cond) else begin
			$display("error at %0t: %s", $time, msg);
			errors++;
		end
	endtask

	task automatic step();
		@(posedge clk);
		#5;
	endtask

	task automatic press_button(input int cycles);
		step();
		btn_reboot = 1'b1;
		repeat (cycles) step();
		btn_reboot = 1'b0;
	endtask

	task automatic apply_reset();
		step();
		rst_n = 1'b0;
		repeat (10) step();
		rst_n = 1'b1;
	endtask

	task automatic check_idle();
		check(icap_ce_n && icap_write_n, "ICAP enables not high");
		check(!led_busy && !led_done && !led_error, "LED not low");
	endtask

	task automatic report_test(input string name, input int mark);
		tests++;
		if (errors == mark)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - mark);
	endtask

	// follows one sequence from its first write; busy_at < 0 means no BUSY
	task automatic watch_sequence(input int busy_at);
		int n;
		n = 0;
		@(negedge clk);
		while (icap_ce_n && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (icap_ce_n) begin
			$display("no ICAP write seen within %0d cycles of the press", n);
			errors++;
		end else begin
			for (int i = 0; i < standby_pkg::seq_len; i++) begin
				check(!icap_ce_n, "gap in the ICAP writes");
				check(led_busy == (i < standby_pkg::seq_len - 1),
					"led_busy wrong in sequence");
				check(led_error == (busy_at >= 0 && i > busy_at),
					"led_error wrong in sequence");
				@(negedge clk);
			end
			repeat (5) begin
				check(icap_ce_n && !led_busy && led_done, "flags wrong after sequence");
				check(led_error == (busy_at >= 0), "led_error wrong after sequence");
				@(negedge clk);
			end
		end
	endtask

	always @(negedge clk) begin
		check(icap_ce_n == icap_write_n, "icap_ce_n and icap_write_n differ");
		if (led_busy || !icap_ce_n)
			activity = 1'b1;
	end

	initial begin
		#(max_cycles * period);
		$display("timeout: run did not finish within %0d cycles", max_cycles);
		$display("Test failed");
		$finish;
	end

	initial begin
		int mark;
		int len;
		rst_n = 1'b0;
		btn_reboot = 1'b0;
		busy_slot = -1;
		{errors, checks, tests} = '0;
		rnd = 32'h9119;
		mark = errors;
		repeat (10) begin
			@(negedge clk);
			check_idle();
		end
		step();
		rst_n = 1'b1;
		repeat (3) begin
			@(negedge clk);
			check_idle();
		end
		report_test("reset state", mark);

		// pulses shorter than the debounce window
		mark = errors;
		activity = 1'b0;
		for (int i = 0; i < 20; i++) begin
			rnd = xorshift32(rnd);
			len = 1 + rnd % 7;
			press_button(len);
			rnd = xorshift32(rnd);
			repeat (9 + rnd % 4) step();
		end
		repeat (12) step();
		check(!activity && model.count == 0, "glitch caused ICAP activity or led_busy");
		report_test("glitch rejection", mark);

		mark = errors;
		fork
			press_button(hold);
			watch_sequence(-1);
		join
		check(model.words.size() == standby_pkg::seq_len, "wrong number of ICAP writes");
		if (model.words.size() == standby_pkg::seq_len) begin
			for (int i = 0; i < standby_pkg::seq_len; i++) begin
				check(model.words[i] == expected_word(i), $sformatf("word %0d is %h", i,
					model.words[i]));
				check(model.stamps[i] == model.stamps[0] + i, "writes not consecutive");
			end
		end
		report_test("reboot sequence", mark);

		// a second press is ignored in done
		mark = errors;
		// accepted level falls back to low before the new press
		repeat (hold) step();
		press_button(hold);
		repeat (20) step();
		check(model.count == standby_pkg::seq_len, "writes after the second press");
		check(led_done && !led_busy, "done state left after the second press");
		report_test("status flags", mark);

		mark = errors;
		apply_reset();
		busy_slot = 4;
		fork
			press_button(hold);
			watch_sequence(busy_slot);
		join
		apply_reset();
		@(negedge clk);
		check(!led_error, "led_error not cleared by reset");
		report_test("busy collision", mark);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
hdl/standby_pkg.sv
hdl/button_sync.sv
hdl/reboot_sequencer.sv
hdl/icap_writer.sv
hdl/standby_top.sv
bench/icap_model.sv
bench/tb_standby.sv
